/* adpcm_sound.f */
+incdir+hw
hw/adpcm_pkg.sv
hw/adpcm_voice_ctrl.sv
hw/sample_rom_arbiter.sv
hw/adpcm_decoder.sv
hw/adpcm_sound.sv
tests/adpcm_sound_properties.sv
tests/adpcm_sound_tb.sv

/* hw/adpcm_decoder.sv */
`timescale 1ns/1ns
`include "adpcm_macros.svh"

module adpcm_decoder
    import adpcm_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        sample_tick,
    input  logic        code_strobe_0,
    input  adpcm_code_t code_0,
    input  logic        restart_0,
    input  logic        code_strobe_1,
    input  adpcm_code_t code_1,
    input  logic        restart_1,
    output snd_sample_t snd,
    output logic        snd_valid
);

    localparam int MAX_IDX = `ADPCM_STEP_COUNT - 1;
    localparam int SIG_MAX = (1 << (`ADPCM_SAMPLE_W - 1)) - 1;
    localparam int SIG_MIN = -(1 << (`ADPCM_SAMPLE_W - 1));

    // oki msm5205 step sizes
    localparam logic [10:0] STEP_TABLE [`ADPCM_STEP_COUNT] = '{
        16, 17, 19, 21, 23, 25, 28, 31, 34, 37, 41, 45, 50, 55, 60, 66,
        73, 80, 88, 97, 107, 118, 130, 143, 157, 173, 190, 209, 230, 253,
        279, 307, 337, 371, 408, 449, 494, 544, 598, 658, 724, 796, 876,
        963, 1060, 1166, 1282, 1411, 1552
    };

    // predictor state per voice
    pcm_sample_t signal_q [2];
    step_index_t index_q [2];

    // pipeline after a tick, ticks need at least 3 cycles between them
    logic        slot1_pend;
    logic        mix_pend;
    logic        pend_strobe_1;
    adpcm_code_t pend_code_1;

    // shared step unit
    logic                            unit_slot;
    logic                            unit_en;
    adpcm_code_t                     unit_code;
    pcm_sample_t                     unit_sig;
    step_index_t                     unit_idx;
    logic [10:0]                     step;
    logic [11:0]                     diff;
    logic signed [13:0]              sum_wide;
    logic signed [7:0]               idx_wide;
    pcm_sample_t                     next_sig;
    step_index_t                     next_idx;
    logic signed [`ADPCM_SAMPLE_W:0] mix_sum;

    // slot 0 straight from the tick, slot 1 one cycle later
    assign unit_slot = slot1_pend;
    assign unit_en   = slot1_pend ? pend_strobe_1 : (sample_tick & code_strobe_0);
    assign unit_code = slot1_pend ? pend_code_1 : code_0;
    assign unit_sig  = signal_q[unit_slot];
    assign unit_idx  = index_q[unit_slot];

    always_comb begin
        step = STEP_TABLE[unit_idx];
        // magnitude bits weight step/4, step/2, step on top of step/8
        diff = {4'b0000, step[10:3]};
        if (unit_code[0]) diff = diff + step[10:2];
        if (unit_code[1]) diff = diff + step[10:1];
        if (unit_code[2]) diff = diff + step;
        sum_wide = unit_sig;
        if (unit_code[3]) begin
            sum_wide = sum_wide - $signed({2'b00, diff});
        end else begin
            sum_wide = sum_wide + $signed({2'b00, diff});
        end
        // saturate to 12 bits
        if (sum_wide > SIG_MAX) begin
            next_sig = pcm_sample_t'(SIG_MAX);
        end else if (sum_wide < SIG_MIN) begin
            next_sig = pcm_sample_t'(SIG_MIN);
        end else begin
            next_sig = sum_wide[11:0];
        end
        // -1 for small codes, +2..+8 for large ones
        idx_wide = $signed({2'b00, unit_idx});
        if (unit_code[2]) begin
            idx_wide = idx_wide + 8'sd2 + $signed({5'b00000, unit_code[1:0], 1'b0});
        end else begin
            idx_wide = idx_wide - 8'sd1;
        end
        if (idx_wide < 0) begin
            next_idx = '0;
        end else if (idx_wide > MAX_IDX) begin
            next_idx = step_index_t'(MAX_IDX);
        end else begin
            next_idx = idx_wide[5:0];
        end
    end

    assign mix_sum = signal_q[0] + signal_q[1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            signal_q[0]   <= '0;
            signal_q[1]   <= '0;
            index_q[0]    <= '0;
            index_q[1]    <= '0;
            slot1_pend    <= 1'b0;
            mix_pend      <= 1'b0;
            pend_strobe_1 <= 1'b0;
            snd           <= '0;
            snd_valid     <= 1'b0;
        end else begin
            slot1_pend <= sample_tick;
            mix_pend   <= slot1_pend;
            snd_valid  <= mix_pend;
            if (sample_tick) begin
                pend_strobe_1 <= code_strobe_1;
            end
            if (unit_en) begin
                signal_q[unit_slot] <= next_sig;
                index_q[unit_slot]  <= next_idx;
            end
            // restart wins over an update
            if (restart_0) begin
                signal_q[0] <= '0;
                index_q[0]  <= '0;
            end
            if (restart_1) begin
                signal_q[1] <= '0;
                index_q[1]  <= '0;
            end
            // times 8, held until the next tick
            if (mix_pend) begin
                snd <= {mix_sum, 3'b000};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample_tick) begin
            pend_code_1 <= code_1;
        end
    end

endmodule

/* hw/adpcm_macros.svh */
`ifndef ADPCM_MACROS_SVH
`define ADPCM_MACROS_SVH

// sample rom address, 32 KiB of bytes
`define ADPCM_ROM_AW 15
// one rom byte carries two codes
`define ADPCM_BYTE_W 8
`define ADPCM_CODE_W 4

// decoder precision per voice
`define ADPCM_SAMPLE_W 12
// mixed output to the dac
`define ADPCM_OUT_W 16

// oki step table
`define ADPCM_STEP_COUNT 49
`define ADPCM_IDX_W 6

// playback length in bytes, zero stands for 256
`define ADPCM_LEN_W 8

`endif

/* hw/adpcm_pkg.sv */
`include "adpcm_macros.svh"

package adpcm_pkg;

    // byte address into the shared sample rom
    typedef logic [`ADPCM_ROM_AW-1:0] rom_addr_t;

    // high nibble plays first
    typedef logic [`ADPCM_BYTE_W-1:0] rom_byte_t;

    // bit 3 sign, bits 2..0 magnitude
    typedef logic [`ADPCM_CODE_W-1:0] adpcm_code_t;

    // decoded voice signal
    typedef logic signed [`ADPCM_SAMPLE_W-1:0] pcm_sample_t;

    // mix of both voices, scaled by 8
    typedef logic signed [`ADPCM_OUT_W-1:0] snd_sample_t;

    // position in the step table, 0..48
    typedef logic [`ADPCM_IDX_W-1:0] step_index_t;

    // zero means a full 256 bytes
    typedef logic [`ADPCM_LEN_W-1:0] byte_count_t;

    // voice sequencer
    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        PLAY_HIGH,
        PLAY_LOW
    } voice_state_e;

    // rom access owner
    typedef enum logic {
        ARB_IDLE,
        ARB_BUSY
    } arb_state_e;

endpackage

/* hw/adpcm_sound.sv */
`timescale 1ns/1ns

module adpcm_sound
    import adpcm_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        sample_tick,
    // voice 0 host side
    input  logic        cmd_valid_0,
    input  rom_addr_t   cmd_addr_0,
    input  byte_count_t cmd_len_0,
    output logic        cmd_ready_0,
    output logic        irq_0,
    input  logic        irq_ack_0,
    // voice 1 host side
    input  logic        cmd_valid_1,
    input  rom_addr_t   cmd_addr_1,
    input  byte_count_t cmd_len_1,
    output logic        cmd_ready_1,
    output logic        irq_1,
    input  logic        irq_ack_1,
    // shared sample rom
    output logic        rom_cs,
    output rom_addr_t   rom_addr,
    input  rom_byte_t   rom_data,
    input  logic        rom_ok,
    // mixed sound
    output snd_sample_t snd,
    output logic        snd_valid
);

    logic        fetch_valid_0;
    logic        fetch_valid_1;
    rom_addr_t   fetch_addr_0;
    rom_addr_t   fetch_addr_1;
    logic        fetch_ready_0;
    logic        fetch_ready_1;
    logic        code_strobe_0;
    logic        code_strobe_1;
    adpcm_code_t code_0;
    adpcm_code_t code_1;
    logic        restart_0;
    logic        restart_1;

    adpcm_voice_ctrl u_voice0 (
        .clk         (clk),
        .rst         (rst),
        .sample_tick (sample_tick),
        .cmd_valid   (cmd_valid_0),
        .cmd_addr    (cmd_addr_0),
        .cmd_len     (cmd_len_0),
        .cmd_ready   (cmd_ready_0),
        .fetch_valid (fetch_valid_0),
        .fetch_addr  (fetch_addr_0),
        .fetch_ready (fetch_ready_0),
        // rom data fans out, only the granted voice latches it
        .rom_data    (rom_data),
        .code_strobe (code_strobe_0),
        .code        (code_0),
        .restart     (restart_0),
        .irq         (irq_0),
        .irq_ack     (irq_ack_0)
    );

    adpcm_voice_ctrl u_voice1 (
        .clk         (clk),
        .rst         (rst),
        .sample_tick (sample_tick),
        .cmd_valid   (cmd_valid_1),
        .cmd_addr    (cmd_addr_1),
        .cmd_len     (cmd_len_1),
        .cmd_ready   (cmd_ready_1),
        .fetch_valid (fetch_valid_1),
        .fetch_addr  (fetch_addr_1),
        .fetch_ready (fetch_ready_1),
        .rom_data    (rom_data),
        .code_strobe (code_strobe_1),
        .code        (code_1),
        .restart     (restart_1),
        .irq         (irq_1),
        .irq_ack     (irq_ack_1)
    );

    sample_rom_arbiter u_arbiter (
        .clk           (clk),
        .rst           (rst),
        .fetch_valid_0 (fetch_valid_0),
        .fetch_addr_0  (fetch_addr_0),
        .fetch_ready_0 (fetch_ready_0),
        .fetch_valid_1 (fetch_valid_1),
        .fetch_addr_1  (fetch_addr_1),
        .fetch_ready_1 (fetch_ready_1),
        .rom_cs        (rom_cs),
        .rom_addr      (rom_addr),
        .rom_ok        (rom_ok)
    );

    adpcm_decoder u_decoder (
        .clk           (clk),
        .rst           (rst),
        .sample_tick   (sample_tick),
        .code_strobe_0 (code_strobe_0),
        .code_0        (code_0),
        .restart_0     (restart_0),
        .code_strobe_1 (code_strobe_1),
        .code_1        (code_1),
        .restart_1     (restart_1),
        .snd           (snd),
        .snd_valid     (snd_valid)
    );

endmodule

/* hw/adpcm_voice_ctrl.sv */
`timescale 1ns/1ns
`include "adpcm_macros.svh"

module adpcm_voice_ctrl
    import adpcm_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        sample_tick,
    // host command
    input  logic        cmd_valid,
    input  rom_addr_t   cmd_addr,
    input  byte_count_t cmd_len,
    output logic        cmd_ready,
    // byte fetch through the arbiter
    output logic        fetch_valid,
    output rom_addr_t   fetch_addr,
    input  logic        fetch_ready,
    input  rom_byte_t   rom_data,
    // codes to the decoder
    output logic        code_strobe,
    output adpcm_code_t code,
    output logic        restart,
    // end of playback
    output logic        irq,
    input  logic        irq_ack
);

    voice_state_e          state;
    rom_byte_t             data_buf;
    logic                  buf_valid;
    adpcm_code_t           low_nib;
    // bytes not fetched yet, one extra bit for 256
    logic [`ADPCM_LEN_W:0] fetch_left;
    logic                  accept;
    logic                  have_byte;

    assign cmd_ready = (state == IDLE);
    assign accept    = cmd_valid & cmd_ready;
    // a byte landing this cycle counts as buffered
    assign have_byte = buf_valid | fetch_ready;

    // codes leave on the tick itself
    assign code_strobe = sample_tick & ((state == PLAY_HIGH) | (state == PLAY_LOW));
    assign code        = (state == PLAY_HIGH) ? data_buf[7:4] : low_nib;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= IDLE;
            fetch_valid <= 1'b0;
            buf_valid   <= 1'b0;
            fetch_left  <= '0;
            restart     <= 1'b0;
            irq         <= 1'b0;
        end else begin
            // decoder clears this slot one cycle after accept
            restart <= accept;
            if (irq_ack) begin
                irq <= 1'b0;
            end
            if (fetch_ready) begin
                buf_valid   <= 1'b1;
                fetch_valid <= 1'b0;
                fetch_left  <= fetch_left - 1'b1;
            end
            case (state)
                IDLE: begin
                    if (accept) begin
                        state       <= FETCH;
                        fetch_valid <= 1'b1;
                        fetch_left  <= {cmd_len == '0, cmd_len};
                        buf_valid   <= 1'b0;
                        irq         <= 1'b0;
                    end
                end
                FETCH: begin
                    // waiting for a byte, ticks here are underruns
                    if (have_byte) begin
                        state <= PLAY_HIGH;
                    end
                end
                PLAY_HIGH: begin
                    if (sample_tick) begin
                        state     <= PLAY_LOW;
                        buf_valid <= 1'b0;
                        // prefetch while the low nibble waits
                        fetch_valid <= (fetch_left != '0);
                    end
                end
                PLAY_LOW: begin
                    if (sample_tick) begin
                        if (have_byte) begin
                            state <= PLAY_HIGH;
                        end else if (fetch_left == '0) begin
                            // last code gone
                            state <= IDLE;
                            irq   <= 1'b1;
                        end else begin
                            state <= FETCH;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (fetch_ready) begin
            data_buf <= rom_data;
        end
        if (accept) begin
            fetch_addr <= cmd_addr;
        end else if (fetch_ready) begin
            fetch_addr <= fetch_addr + 1'b1;
        end
        // keep low nibble so the buffer is free for prefetch
        if (sample_tick && state == PLAY_HIGH) begin
            low_nib <= data_buf[3:0];
        end
    end

endmodule

/* hw/sample_rom_arbiter.sv */
`timescale 1ns/1ns

module sample_rom_arbiter
    import adpcm_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    // voice 0 requester
    input  logic      fetch_valid_0,
    input  rom_addr_t fetch_addr_0,
    output logic      fetch_ready_0,
    // voice 1 requester
    input  logic      fetch_valid_1,
    input  rom_addr_t fetch_addr_1,
    output logic      fetch_ready_1,
    // rom side, cs held until ok
    output logic      rom_cs,
    output rom_addr_t rom_addr,
    input  logic      rom_ok
);

    arb_state_e state;
    // voice owning the access in flight
    logic       grant;
    // voice served by the previous access
    logic       last;
    logic       pick;
    logic       any_req;

    assign any_req = fetch_valid_0 | fetch_valid_1;
    // both waiting: the other one goes first
    assign pick = (fetch_valid_0 & fetch_valid_1) ? ~last : fetch_valid_1;

    assign rom_cs = (state == ARB_BUSY);

    // ok strobe routed to the owner only
    assign fetch_ready_0 = rom_cs & rom_ok & ~grant;
    assign fetch_ready_1 = rom_cs & rom_ok & grant;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ARB_IDLE;
            grant <= 1'b0;
            // voice 0 wins the first tie
            last  <= 1'b1;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (any_req) begin
                        state <= ARB_BUSY;
                        grant <= pick;
                    end
                end
                ARB_BUSY: begin
                    // latency is open ended
                    if (rom_ok) begin
                        state <= ARB_IDLE;
                        last  <= grant;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // address latched at grant, stable until ok
    always_ff @(posedge clk) begin
        if (state == ARB_IDLE && any_req) begin
            rom_addr <= pick ? fetch_addr_1 : fetch_addr_0;
        end
    end

endmodule

/* tests/adpcm_sound_properties.sv */
`timescale 1ns/1ns

module adpcm_sound_properties
    import adpcm_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      rom_cs,
    input rom_addr_t rom_addr,
    input logic      rom_ok,
    input logic      fetch_ready_0,
    input logic      fetch_ready_1
);

    // assertion failures seen so far
    int fail_count = 0;

    // address frozen while the rom works on it
    property p_addr_hold;
        @(posedge clk) disable iff (rst)
        (rom_cs && !rom_ok) |=> $stable(rom_addr);
    endproperty
    a_addr_hold: assert property (p_addr_hold)
        else begin
            fail_count++;
            $error("rom address moved during a pending access");
        end

    // cs stays up until the ok strobe
    property p_cs_hold;
        @(posedge clk) disable iff (rst)
        (rom_cs && !rom_ok) |=> rom_cs;
    endproperty
    a_cs_hold: assert property (p_cs_hold)
        else begin
            fail_count++;
            $error("rom chip select dropped before ok");
        end

    // one owner per access
    property p_ready_onehot;
        @(posedge clk) disable iff (rst)
        !(fetch_ready_0 && fetch_ready_1);
    endproperty
    a_ready_onehot: assert property (p_ready_onehot)
        else begin
            fail_count++;
            $error("both fetch_ready outputs high in one cycle");
        end

    // ready is the routed ok strobe
    property p_ready_with_ok;
        @(posedge clk) disable iff (rst)
        (fetch_ready_0 || fetch_ready_1) |-> (rom_ok && rom_cs);
    endproperty
    a_ready_with_ok: assert property (p_ready_with_ok)
        else begin
            fail_count++;
            $error("fetch_ready pulse without rom_ok");
        end

endmodule

bind sample_rom_arbiter adpcm_sound_properties u_properties (
    .clk           (clk),
    .rst           (rst),
    .rom_cs        (rom_cs),
    .rom_addr      (rom_addr),
    .rom_ok        (rom_ok),
    .fetch_ready_0 (fetch_ready_0),
    .fetch_ready_1 (fetch_ready_1)
);

/* tests/adpcm_sound_tb.sv */
`timescale 1ns/1ns
`include "adpcm_macros.svh"

module adpcm_sound_tb
    import adpcm_pkg::*;
;

    logic        clk = 1'b0;
    logic        rst;
    logic        sample_tick;
    logic        cmd_valid_0;
    rom_addr_t   cmd_addr_0;
    byte_count_t cmd_len_0;
    logic        cmd_ready_0;
    logic        irq_0;
    logic        irq_ack_0;
    logic        cmd_valid_1;
    rom_addr_t   cmd_addr_1;
    byte_count_t cmd_len_1;
    logic        cmd_ready_1;
    logic        irq_1;
    logic        irq_ack_1;
    logic        rom_cs;
    rom_addr_t   rom_addr;
    rom_byte_t   rom_data;
    logic        rom_ok;
    snd_sample_t snd;
    logic        snd_valid;
    logic [1:0]  irq_vec;
    logic [1:0]  ready_vec;

    // oki step sizes as listed for the msm5205
    localparam int STEP_TAB [`ADPCM_STEP_COUNT] = '{
        16, 17, 19, 21, 23, 25, 28, 31, 34, 37, 41, 45, 50, 55, 60, 66,
        73, 80, 88, 97, 107, 118, 130, 143, 157, 173, 190, 209, 230, 253,
        279, 307, 337, 371, 408, 449, 494, 544, 598, 658, 724, 796, 876,
        963, 1060, 1166, 1282, 1411, 1552
    };

    rom_byte_t   rom_mem [0:32767];
    logic [31:0] lfsr_state = 32'h0b3f30bb;
    int          tick_cnt;
    int          delay_left;
    int          error_count = 0;
    int          check_count = 0;
    string       test_name = "none";

    // mirrored voice state
    rom_addr_t   ref_addr [2];
    int          ref_left [2];
    int          ref_pos [2];
    int          ref_sig [2];
    int          ref_idx [2];
    bit          irq_due [2];
    bit          clamp_lo_seen;
    bit          clamp_hi_seen;
    int          exp_q [$];
    int          tick_q [$];
    int          cycle = 0;

    assign irq_vec   = {irq_1, irq_0};
    assign ready_vec = {cmd_ready_1, cmd_ready_0};

    adpcm_sound i_adpcm_sound (
        .clk         (clk),
        .rst         (rst),
        .sample_tick (sample_tick),
        .cmd_valid_0 (cmd_valid_0),
        .cmd_addr_0  (cmd_addr_0),
        .cmd_len_0   (cmd_len_0),
        .cmd_ready_0 (cmd_ready_0),
        .irq_0       (irq_0),
        .irq_ack_0   (irq_ack_0),
        .cmd_valid_1 (cmd_valid_1),
        .cmd_addr_1  (cmd_addr_1),
        .cmd_len_1   (cmd_len_1),
        .cmd_ready_1 (cmd_ready_1),
        .irq_1       (irq_1),
        .irq_ack_1   (irq_ack_1),
        .rom_cs      (rom_cs),
        .rom_addr    (rom_addr),
        .rom_data    (rom_data),
        .rom_ok      (rom_ok),
        .snd         (snd),
        .snd_valid   (snd_valid)
    );

    always #2 clk = ~clk;

    // galois lfsr stepped once per bit
    function automatic logic [31:0] lfsr_take(input int nbits);
        logic [31:0] val;
        int          i;
        val = '0;
        for (i = 0; i < nbits; i++) begin
            val = {val[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return val;
    endfunction

    // one decode step of the oki algorithm
    function automatic void adpcm_ref_step(input int sig_in, input int idx_in,
                                           input logic [3:0] c, output int sig_out,
                                           output int idx_out, output bit lo, output bit hi);
        int step;
        int diff;
        int idx_raw;
        step = STEP_TAB[idx_in];
        diff = step / 8;
        if (c[0]) diff = diff + step / 4;
        if (c[1]) diff = diff + step / 2;
        if (c[2]) diff = diff + step;
        sig_out = c[3] ? sig_in - diff : sig_in + diff;
        if (sig_out > 2047) sig_out = 2047;
        if (sig_out < -2048) sig_out = -2048;
        // small magnitudes shrink the step and large ones grow it by 2..8
        idx_raw = (c[2:0] < 4) ? idx_in - 1 : idx_in + 2 * (c[2:0] - 3);
        lo = (idx_raw < 0);
        hi = (idx_raw > 48);
        idx_out = lo ? 0 : (hi ? 48 : idx_raw);
    endfunction

    // scoreboard errors plus failed bound assertions
    function automatic int total_errors();
        return error_count + i_adpcm_sound.u_arbiter.u_properties.fail_count;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        check_count++;
        assert (expected == actual) else begin
            error_count++;
            $display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic report_error(input string what);
        error_count++;
        $display("ERROR in %s: %s", test_name, what);
    endtask

    task automatic abort_run(input string what);
        error_count++;
        $display("timeout in %s while waiting for %s", test_name, what);
        $display("checks %0d, errors %0d", check_count, total_errors());
        $display("Verification failed");
        $finish;
    endtask

    task automatic mirror_accept(input int v, input rom_addr_t addr, input byte_count_t len);
        ref_addr[v] = addr;
        ref_left[v] = (len == 0) ? 512 : 2 * len;
        ref_pos[v]  = 0;
        ref_sig[v]  = 0;
        ref_idx[v]  = 0;
    endtask

    // tick every 40 cycles
    always @(posedge clk) begin
        if (rst) begin
            tick_cnt    <= 0;
            sample_tick <= 1'b0;
        end else begin
            tick_cnt    <= (tick_cnt == 39) ? 0 : tick_cnt + 1;
            sample_tick <= (tick_cnt == 39);
        end
    end

    // rom answers after 1 to 6 cycles
    always @(posedge clk) begin
        if (rst) begin
            rom_ok     <= 1'b0;
            delay_left = -1;
        end else if (rom_ok) begin
            rom_ok     <= 1'b0;
            delay_left = -1;
        end else if (rom_cs) begin
            if (delay_left < 0) begin
                delay_left = (lfsr_take(3) % 6) + 1;
            end
            delay_left = delay_left - 1;
            if (delay_left == 0) begin
                rom_ok   <= 1'b1;
                rom_data <= rom_mem[rom_addr];
            end
        end
    end

    // scoreboard mirrors the voices and compares every output
    always @(posedge clk) begin : scoreboard
        int        v;
        int        exp_val;
        int        t;
        rom_byte_t rbyte;
        logic [3:0] rcode;
        bit        lo;
        bit        hi;
        if (!rst) begin
            for (v = 0; v < 2; v++) begin
                if (irq_due[v]) begin
                    check_value($sformatf("%s_irq_rise_%0d", test_name, v), 1, irq_vec[v]);
                    irq_due[v] = 1'b0;
                end
                // a playing voice is neither ready nor interrupting
                if (ref_left[v] != 0) begin
                    assert (!irq_vec[v] && !ready_vec[v]) else
                        report_error($sformatf("voice %0d idle or interrupting mid playback", v));
                end
            end
            if (snd_valid) begin
                assert (exp_q.size() != 0) else
                    report_error("snd_valid without a preceding tick");
                if (exp_q.size() != 0) begin
                    exp_val = exp_q.pop_front();
                    t = tick_q.pop_front();
                    check_value(test_name, exp_val, snd);
                    check_value({test_name, "_latency"}, 3, cycle - t);
                end
            end
            if (cmd_valid_0 && cmd_ready_0) mirror_accept(0, cmd_addr_0, cmd_len_0);
            if (cmd_valid_1 && cmd_ready_1) mirror_accept(1, cmd_addr_1, cmd_len_1);
            if (sample_tick) begin
                for (v = 0; v < 2; v++) begin
                    if (ref_left[v] > 0) begin
                        rbyte = rom_mem[rom_addr_t'(ref_addr[v] + ref_pos[v] / 2)];
                        // high nibble first
                        rcode = (ref_pos[v] % 2 == 0) ? rbyte[7:4] : rbyte[3:0];
                        adpcm_ref_step(ref_sig[v], ref_idx[v], rcode, ref_sig[v], ref_idx[v],
                                       lo, hi);
                        if (lo) clamp_lo_seen = 1'b1;
                        if (hi) clamp_hi_seen = 1'b1;
                        ref_pos[v]++;
                        ref_left[v]--;
                        if (ref_left[v] == 0) irq_due[v] = 1'b1;
                    end
                end
                exp_q.push_back(8 * (ref_sig[0] + ref_sig[1]));
                tick_q.push_back(cycle);
            end
        end
        cycle++;
    end

    task automatic wait_tick();
        int n;
        bit seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < 100) begin
            @(posedge clk);
            seen = sample_tick;
            n++;
        end
        if (!seen) abort_run("sample tick");
    endtask

    task automatic wait_irq(input int v, input int limit);
        int n;
        for (n = 0; n < limit && !irq_vec[v]; n++) begin
            @(posedge clk);
        end
        if (!irq_vec[v]) abort_run($sformatf("irq of voice %0d", v));
    endtask

    // commands go out just after a tick and far from the next one
    task automatic send_cmds(input bit en0, input rom_addr_t a0, input byte_count_t l0,
                             input bit en1, input rom_addr_t a1, input byte_count_t l1);
        bit pend0;
        bit pend1;
        int n;
        pend0 = en0;
        pend1 = en1;
        wait_tick();
        @(posedge clk);
        cmd_valid_0 <= en0;
        cmd_addr_0  <= a0;
        cmd_len_0   <= l0;
        cmd_valid_1 <= en1;
        cmd_addr_1  <= a1;
        cmd_len_1   <= l1;
        for (n = 0; n < 20 && (pend0 || pend1); n++) begin
            @(posedge clk);
            if (pend0 && cmd_valid_0 && cmd_ready_0) begin
                pend0 = 1'b0;
                cmd_valid_0 <= 1'b0;
            end
            if (pend1 && cmd_valid_1 && cmd_ready_1) begin
                pend1 = 1'b0;
                cmd_valid_1 <= 1'b0;
            end
        end
        if (pend0 || pend1) abort_run("command accept");
    endtask

    task automatic ack_irq(input int v);
        @(posedge clk);
        if (v == 0) irq_ack_0 <= 1'b1;
        else irq_ack_1 <= 1'b1;
        @(posedge clk);
        irq_ack_0 <= 1'b0;
        irq_ack_1 <= 1'b0;
        @(posedge clk);
    endtask

    initial begin
        int i;
        int n;
        rst         = 1'b1;
        sample_tick = 1'b0;
        cmd_valid_0 = 1'b0;
        cmd_addr_0  = '0;
        cmd_len_0   = '0;
        irq_ack_0   = 1'b0;
        cmd_valid_1 = 1'b0;
        cmd_addr_1  = '0;
        cmd_len_1   = '0;
        irq_ack_1   = 1'b0;
        rom_data    = '0;
        rom_ok      = 1'b0;
        for (i = 0; i < 2; i++) begin
            mirror_accept(i, '0, 8'd1);
            ref_left[i] = 0;
            irq_due[i]  = 1'b0;
        end
        for (i = 0; i < 32768; i++) begin
            rom_mem[i] = lfsr_take(8);
        end
        // quiet first byte pushes the index below 0
        rom_mem[15'h2000] = 8'h00;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        test_name = "reset_state";
        @(posedge clk);
        check_value("reset_cmd_ready_0", 1, cmd_ready_0);
        check_value("reset_cmd_ready_1", 1, cmd_ready_1);
        check_value("reset_irq_0", 0, irq_0);
        check_value("reset_irq_1", 0, irq_1);
        check_value("reset_snd", 0, snd);
        check_value("reset_snd_valid", 0, snd_valid);
        check_value("reset_rom_cs", 0, rom_cs);

        test_name = "single_voice";
        send_cmds(1'b1, 15'h0100, 8'd4, 1'b0, '0, '0);
        wait_irq(0, 10 * 40 + 200);
        // sticky until acknowledged
        repeat (10) @(posedge clk);
        check_value("single_voice_irq_held", 1, irq_0);
        ack_irq(0);
        check_value("single_voice_irq_cleared", 0, irq_0);

        test_name = "two_voices";
        send_cmds(1'b1, 15'h1200, 8'd6, 1'b1, 15'h5a31, 8'd3);
        wait_irq(1, 8 * 40 + 200);
        wait_irq(0, 14 * 40 + 200);
        ack_irq(0);
        ack_irq(1);

        test_name = "restart_voice";
        // voice 0 still holds the end of its last sample
        assert (ref_sig[0] != 0) else
            report_error("voice 0 held signal is 0 before the restart");
        send_cmds(1'b1, 15'h0777, 8'd2, 1'b0, '0, '0);
        wait_irq(0, 6 * 40 + 200);
        ack_irq(0);

        test_name = "length_256";
        clamp_lo_seen = 1'b0;
        clamp_hi_seen = 1'b0;
        send_cmds(1'b0, '0, '0, 1'b1, 15'h2000, 8'd0);
        wait_irq(1, 514 * 40 + 200);
        ack_irq(1);
        check_value("length_256_index_clamp_low", 1, clamp_lo_seen);
        check_value("length_256_index_clamp_high", 1, clamp_hi_seen);

        // let the last output through
        test_name = "drain";
        wait_tick();
        @(posedge clk);
        for (n = 0; n < 10 && exp_q.size() != 0; n++) begin
            @(posedge clk);
        end
        if (exp_q.size() != 0) abort_run("last sound output");

        $display("checks %0d, errors %0d", check_count, total_errors());
        if (total_errors() == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
